//--- src.f
+incdir+.
cpu_pkg.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
samming_cpu.sv
tb_data_mem.sv
tb_samming_cpu.sv

//--- Makefile
SIM      := verilator
TOP      := tb_samming_cpu
FILELIST := src.f
FLAGS    := --binary --assert --timescale 1ns/1ps
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

//--- tb_samming_cpu.sv
`include "cpu_macros.svh"

module tb_samming_cpu import cpu_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_WB      = 15;
	localparam int WB_TIMEOUT  = 60;
	localparam int IDLE_CYCLES = 20;

	logic      clk;
	logic      reset_i;
	word_t     imem_addr;
	word_t     imem_data;
	logic      dmem_req;
	logic      dmem_we;
	word_t     dmem_addr;
	word_t     dmem_wdata;
	logic      dmem_ack;
	word_t     dmem_rdata;
	logic      wb_we;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      mem_violation;

	// program, zero words past the end run as nops
	word_t     prog [32];

	// expected write-backs in program order
	string     wb_name  [NUM_WB];
	reg_addr_t wb_reg   [NUM_WB];
	word_t     wb_value [NUM_WB];

	samming_cpu i_samming_cpu (
		.clk(clk), .reset_i(reset_i),
		.imem_addr_o(imem_addr), .imem_data_i(imem_data),
		.dmem_req_o(dmem_req), .dmem_we_o(dmem_we),
		.dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
		.dmem_ack_i(dmem_ack), .dmem_rdata_i(dmem_rdata),
		.wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
	);

	tb_data_mem i_data_mem (
		.clk(clk), .reset_i(reset_i),
		.req_i(dmem_req), .we_i(dmem_we), .addr_i(dmem_addr), .wdata_i(dmem_wdata),
		.ack_o(dmem_ack), .rdata_o(dmem_rdata), .violation_o(mem_violation)
	);

	always #50 clk = ~clk;

	// combinational instruction port
	assign imem_data = (imem_addr[31:7] == '0) ? prog[imem_addr[6:2]] : 32'h0000_0000;

	//////////////////////////////////////////////////
	// instruction encoding and tables

	function automatic word_t r_format(input logic [5:0] fn, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt);
		return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_format(input logic [5:0] op, input reg_addr_t rt,
		input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_expect(input int idx, input string name, input reg_addr_t rd,
		input word_t value);
		wb_name[idx]  = name;
		wb_reg[idx]   = rd;
		wb_value[idx] = value;
	endtask

	task automatic load_tables();
		for (int i = 0; i < 32; i++) begin
			prog[i] = 32'h0000_0000;
		end
		prog[0]  = i_format(`OP_LUI,   5'd1,  5'd0,  16'h1234);
		prog[1]  = i_format(`OP_ORI,   5'd1,  5'd1,  16'h5678);
		prog[2]  = i_format(`OP_LUI,   5'd2,  5'd0,  16'hFFFF);
		prog[3]  = r_format(`FN_ADDU,  5'd3,  5'd1,  5'd2);
		prog[4]  = r_format(`FN_SUBU,  5'd4,  5'd3,  5'd1);
		prog[5]  = r_format(`FN_AND,   5'd5,  5'd4,  5'd1);
		prog[6]  = r_format(`FN_OR,    5'd6,  5'd5,  5'd2);
		prog[7]  = r_format(`FN_XOR,   5'd7,  5'd6,  5'd3);
		prog[8]  = r_format(`FN_SLT,   5'd8,  5'd4,  5'd1);
		prog[9]  = r_format(`FN_SLT,   5'd9,  5'd1,  5'd4);
		prog[10] = i_format(`OP_ADDIU, 5'd0,  5'd1,  16'h0005);
		prog[11] = r_format(`FN_ADDU,  5'd10, 5'd0,  5'd8);
		prog[12] = i_format(`OP_ADDIU, 5'd11, 5'd0,  16'h0040);
		prog[13] = i_format(`OP_SW,    5'd7,  5'd11, 16'h0008);
		prog[14] = i_format(`OP_LW,    5'd12, 5'd11, 16'h0008);
		prog[15] = r_format(`FN_ADDU,  5'd13, 5'd12, 5'd1);
		prog[16] = i_format(`OP_ADDIU, 5'd14, 5'd13, 16'hFFFF);

		// worked out by hand, the addiu to r0 retires nothing
		add_expect(0,  "lui r1",               5'd1,  32'h1234_0000);
		add_expect(1,  "ori r1 ex bypass",     5'd1,  32'h1234_5678);
		add_expect(2,  "lui r2",               5'd2,  32'hFFFF_0000);
		add_expect(3,  "addu r3 both bypass",  5'd3,  32'h1233_5678);
		add_expect(4,  "subu r4",              5'd4,  32'hFFFF_0000);
		add_expect(5,  "and r5",               5'd5,  32'h1234_0000);
		add_expect(6,  "or r6",                5'd6,  32'hFFFF_0000);
		add_expect(7,  "xor r7",               5'd7,  32'hEDCC_5678);
		add_expect(8,  "slt r8 negative lhs",  5'd8,  32'h0000_0001);
		add_expect(9,  "slt r9 negative rhs",  5'd9,  32'h0000_0000);
		add_expect(10, "addu r10 reads r0",    5'd10, 32'h0000_0001);
		add_expect(11, "addiu r11",            5'd11, 32'h0000_0040);
		add_expect(12, "lw r12",               5'd12, 32'hEDCC_5678);
		add_expect(13, "addu r13 load-use",    5'd13, 32'h0000_ACF0);
		add_expect(14, "addiu r14 sign ext",   5'd14, 32'h0000_ACEF);
	endtask

	//////////////////////////////////////////////////
	// checks

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_reg_addr(input string name, input reg_addr_t expected,
		input reg_addr_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
			fail_run();
		end
	endtask

	task automatic wait_for_wb(input string name);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WB_TIMEOUT) begin
				$display("ERROR: no write-back for %s within %0d cycles", name, WB_TIMEOUT);
				fail_run();
			end
		end while (!wb_we);
	endtask

	// port invariant and data memory protocol
	always @(negedge clk) begin
		if (!reset_i && wb_we && wb_addr == '0) begin
			$display("ERROR: write-back port wrote register 0");
			fail_run();
		end
		if (mem_violation) begin
			$display("ERROR: data memory saw a four-phase handshake violation");
			fail_run();
		end
	end

	//////////////////////////////////////////////////
	// stimulus

	initial begin
		clk     = 1'b0;
		reset_i <= 1'b1;
		load_tables();
		@(posedge clk);
		@(negedge clk);
		check_bit("reset dmem_req_o", 1'b0, dmem_req);
		check_bit("reset wb_we_o", 1'b0, wb_we);
		check_word("reset imem_addr_o", `RESET_PC, imem_addr);
		@(posedge clk);
		reset_i <= 1'b0;

		for (int i = 0; i < NUM_WB; i++) begin
			wait_for_wb(wb_name[i]);
			check_reg_addr(wb_name[i], wb_reg[i], wb_addr);
			check_word(wb_name[i], wb_value[i], wb_data);
		end

		// sw went to byte address 0x48, word 18
		check_word("sw copy in data memory", 32'hEDCC_5678, i_data_mem.mem[18]);

		// only nops left, nothing may retire
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_bit("write-back after program end", 1'b0, wb_we);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- tb_data_mem.sv
module tb_data_mem import cpu_pkg::*; (
	input  logic  clk,
	input  logic  reset_i,
	input  logic  req_i,
	input  logic  we_i,
	input  word_t addr_i,
	input  word_t wdata_i,
	output logic  ack_o,
	output word_t rdata_o,
	output logic  violation_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WORDS = 64;

	word_t      mem [WORDS];
	integer     seed;
	logic [1:0] delay_q;
	logic       req_q;
	logic       we_lat;
	word_t      addr_lat;
	word_t      wdata_lat;

	// fill derived from the word's byte address
	initial begin
		seed        = 30954;
		ack_o       = 1'b0;
		rdata_o     = '0;
		violation_o = 1'b0;
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = 32'h5A00_0000 | (i << 2);
		end
	end

	//////////////////////////////////////////////////
	// four-phase slave, 0 to 3 idle cycles before ack

	always @(posedge clk) begin : handshake
		integer rnd;
		if (reset_i) begin
			ack_o   <= 1'b0;
			rdata_o <= '0;
			delay_q <= 2'd0;
		end else if (ack_o) begin
			// ack stays up until the master lets go of req
			if (!req_i) ack_o <= 1'b0;
		end else if (req_i) begin
			if (delay_q == 2'd0) begin
				ack_o   <= 1'b1;
				rdata_o <= mem[addr_i[7:2]];
				if (we_i) mem[addr_i[7:2]] <= wdata_i;
				rnd     = $random(seed);
				delay_q <= rnd[1:0];
			end else begin
				delay_q <= delay_q - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// protocol checks

	always @(posedge clk) begin
		if (reset_i) begin
			req_q       <= 1'b0;
			violation_o <= 1'b0;
		end else begin
			req_q <= req_i;
			if (req_i && !req_q) begin
				addr_lat  <= addr_i;
				we_lat    <= we_i;
				wdata_lat <= wdata_i;
				if (ack_o) begin
					$display("ERROR: new dmem request raised before ack fell");
					violation_o <= 1'b1;
				end
				if (addr_i[31:8] != '0 || addr_i[1:0] != 2'b00) begin
					$display("ERROR: dmem address %h is outside the data memory", addr_i);
					violation_o <= 1'b1;
				end
			end else if (req_i || ack_o) begin
				if (addr_i != addr_lat || we_i != we_lat || wdata_i != wdata_lat) begin
					$display("ERROR: dmem address, write enable or data changed in a handshake");
					violation_o <= 1'b1;
				end
			end
		end
	end

endmodule

//--- samming_cpu.sv
module samming_cpu import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	output word_t     imem_addr_o,
	input  word_t     imem_data_i,
	output logic      dmem_req_o,
	output logic      dmem_we_o,
	output word_t     dmem_addr_o,
	output word_t     dmem_wdata_o,
	input  logic      dmem_ack_i,
	input  word_t     dmem_rdata_i,
	output logic      wb_we_o,
	output reg_addr_t wb_addr_o,
	output word_t     wb_data_o
);

	// stall controls
	logic      fetch_hold;
	logic      mem_busy;

	// IF/ID and register file
	word_t     id_inst;
	logic      id_valid;
	reg_addr_t rf_raddr1;
	reg_addr_t rf_raddr2;
	word_t     rf_rdata1;
	word_t     rf_rdata2;

	// ID/EX
	alu_op_t   ex_alu_op;
	word_t     ex_opa;
	word_t     ex_opb;
	word_t     ex_store_data;
	mem_op_t   ex_mem_op;
	logic      ex_wreg;
	reg_addr_t ex_wd;

	// EX/MEM, also the newest bypass source
	word_t     mem_result;
	word_t     mem_store_data;
	mem_op_t   mem_op;
	logic      mem_wreg;
	reg_addr_t mem_wd;

	fetch_stage i_fetch_stage (
		.clk(clk), .reset_i(reset_i), .hold_i(fetch_hold),
		.imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o),
		.id_inst_o(id_inst), .id_valid_o(id_valid)
	);

	decode_stage i_decode_stage (
		.clk(clk), .reset_i(reset_i), .mem_busy_i(mem_busy),
		.id_valid_i(id_valid), .id_inst_i(id_inst),
		.rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2),
		.rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
		.ex_wreg_i(mem_wreg), .ex_wd_i(mem_wd), .ex_wdata_i(mem_result), .ex_mem_op_i(mem_op),
		.wb_wreg_i(wb_we_o), .wb_wd_i(wb_addr_o), .wb_wdata_i(wb_data_o),
		.fetch_hold_o(fetch_hold),
		.ex_alu_op_o(ex_alu_op), .ex_opa_o(ex_opa), .ex_opb_o(ex_opb),
		.ex_store_data_o(ex_store_data), .ex_mem_op_o(ex_mem_op),
		.ex_wreg_o(ex_wreg), .ex_wd_o(ex_wd)
	);

	regfile i_regfile (
		.clk(clk), .reset_i(reset_i),
		.we_i(wb_we_o), .waddr_i(wb_addr_o), .wdata_i(wb_data_o),
		.raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
		.rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
	);

	execute_stage i_execute_stage (
		.clk(clk), .reset_i(reset_i), .mem_busy_i(mem_busy),
		.alu_op_i(ex_alu_op), .opa_i(ex_opa), .opb_i(ex_opb),
		.store_data_i(ex_store_data), .mem_op_i(ex_mem_op),
		.wreg_i(ex_wreg), .wd_i(ex_wd),
		.mem_result_o(mem_result), .mem_store_data_o(mem_store_data),
		.mem_op_o(mem_op), .mem_wreg_o(mem_wreg), .mem_wd_o(mem_wd)
	);

	mem_stage i_mem_stage (
		.clk(clk), .reset_i(reset_i),
		.result_i(mem_result), .store_data_i(mem_store_data), .mem_op_i(mem_op),
		.wreg_i(mem_wreg), .wd_i(mem_wd),
		.dmem_req_o(dmem_req_o), .dmem_we_o(dmem_we_o),
		.dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
		.dmem_ack_i(dmem_ack_i), .dmem_rdata_i(dmem_rdata_i),
		.mem_busy_o(mem_busy),
		.wb_we_o(wb_we_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
	);

endmodule

//--- mem_stage.sv
module mem_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  word_t     result_i,
	input  word_t     store_data_i,
	input  mem_op_t   mem_op_i,
	input  logic      wreg_i,
	input  reg_addr_t wd_i,
	output logic      dmem_req_o,
	output logic      dmem_we_o,
	output word_t     dmem_addr_o,
	output word_t     dmem_wdata_o,
	input  logic      dmem_ack_i,
	input  word_t     dmem_rdata_i,
	output logic      mem_busy_o,
	output logic      wb_we_o,
	output reg_addr_t wb_addr_o,
	output word_t     wb_data_o
);

	mem_state_t state_q;
	mem_state_t state_d;
	logic       busy;
	word_t      load_q;
	logic       wb_we_q;
	reg_addr_t  wb_addr_q;
	word_t      wb_data_q;

	//////////////////////////////////////////////////
	// four-phase handshake FSM

	always_comb begin
		state_d = state_q;
		busy    = 1'b1;
		case (state_q)
			MS_IDLE: begin
				busy = (mem_op_i != MEM_NONE);
				if (busy) state_d = MS_REQ;
			end
			MS_REQ: begin
				if (dmem_ack_i) state_d = MS_RELEASE;
			end
			MS_RELEASE: begin
				// done once the slave has dropped ack
				busy = dmem_ack_i;
				if (!dmem_ack_i) state_d = MS_IDLE;
			end
			default: state_d = MS_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= MS_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// rdata valid only alongside ack
	always_ff @(posedge clk) begin
		if (state_q == MS_REQ && dmem_ack_i) begin
			load_q <= dmem_rdata_i;
		end
	end

	// addr and data come from the frozen EX/MEM register
	assign dmem_req_o   = (state_q == MS_REQ);
	assign dmem_we_o    = (mem_op_i == MEM_STORE);
	assign dmem_addr_o  = result_i;
	assign dmem_wdata_o = store_data_i;
	assign mem_busy_o   = busy;

	//////////////////////////////////////////////////
	// MEM/WB register, bubble while busy

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_we_q <= 1'b0;
		end else begin
			wb_we_q <= !busy && wreg_i && (wd_i != '0);
		end
	end

	always_ff @(posedge clk) begin
		wb_addr_q <= wd_i;
		wb_data_q <= (mem_op_i == MEM_LOAD) ? load_q : result_i;
	end

	assign wb_we_o   = wb_we_q;
	assign wb_addr_o = wb_addr_q;
	assign wb_data_o = wb_data_q;

	a_req_until_ack: assert property (@(posedge clk) disable iff (reset_i)
		dmem_req_o && !dmem_ack_i |=> dmem_req_o)
		else $error("dmem req dropped before ack");

	a_addr_stable: assert property (@(posedge clk) disable iff (reset_i)
		dmem_req_o |=> $stable(dmem_addr_o))
		else $error("dmem addr changed during handshake");

endmodule

//--- execute_stage.sv
module execute_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      mem_busy_i,
	input  alu_op_t   alu_op_i,
	input  word_t     opa_i,
	input  word_t     opb_i,
	input  word_t     store_data_i,
	input  mem_op_t   mem_op_i,
	input  logic      wreg_i,
	input  reg_addr_t wd_i,
	output word_t     mem_result_o,
	output word_t     mem_store_data_o,
	output mem_op_t   mem_op_o,
	output logic      mem_wreg_o,
	output reg_addr_t mem_wd_o
);

	word_t     alu_result;
	word_t     result_q;
	word_t     store_data_q;
	mem_op_t   mem_op_q;
	logic      wreg_q;
	reg_addr_t wd_q;

	// also the byte address for lw/sw
	always_comb begin
		case (alu_op_i)
			ALU_ADD: alu_result = opa_i + opb_i;
			ALU_SUB: alu_result = opa_i - opb_i;
			ALU_AND: alu_result = opa_i & opb_i;
			ALU_OR:  alu_result = opa_i | opb_i;
			ALU_XOR: alu_result = opa_i ^ opb_i;
			ALU_SLT: alu_result = {31'd0, $signed(opa_i) < $signed(opb_i)};
			ALU_LUI: alu_result = {opb_i[15:0], 16'h0000};
			default: alu_result = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// EX/MEM register, frozen during a data access

	always_ff @(posedge clk) begin
		if (reset_i) begin
			mem_op_q <= MEM_NONE;
			wreg_q   <= 1'b0;
		end else if (!mem_busy_i) begin
			mem_op_q <= mem_op_i;
			wreg_q   <= wreg_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy_i) begin
			result_q     <= alu_result;
			store_data_q <= store_data_i;
			wd_q         <= wd_i;
		end
	end

	assign mem_result_o     = result_q;
	assign mem_store_data_o = store_data_q;
	assign mem_op_o         = mem_op_q;
	assign mem_wreg_o       = wreg_q;
	assign mem_wd_o         = wd_q;

endmodule

//--- decode_stage.sv
`include "cpu_macros.svh"

module decode_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      mem_busy_i,
	input  logic      id_valid_i,
	input  word_t     id_inst_i,
	output reg_addr_t rf_raddr1_o,
	output reg_addr_t rf_raddr2_o,
	input  word_t     rf_rdata1_i,
	input  word_t     rf_rdata2_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  mem_op_t   ex_mem_op_i,
	input  logic      wb_wreg_i,
	input  reg_addr_t wb_wd_i,
	input  word_t     wb_wdata_i,
	output logic      fetch_hold_o,
	output alu_op_t   ex_alu_op_o,
	output word_t     ex_opa_o,
	output word_t     ex_opb_o,
	output word_t     ex_store_data_o,
	output mem_op_t   ex_mem_op_o,
	output logic      ex_wreg_o,
	output reg_addr_t ex_wd_o
);

	logic [5:0] opcode;
	logic [5:0] funct;
	word_t      imm_sext;
	word_t      imm_zext;

	// decoded fields, a source index of 0 means unused
	alu_op_t    dec_alu_op;
	mem_op_t    dec_mem_op;
	logic       dec_wreg;
	reg_addr_t  dec_wd;
	reg_addr_t  dec_rs;
	reg_addr_t  dec_rt;
	logic       dec_use_imm;
	word_t      dec_imm;

	// ID/EX register
	alu_op_t    alu_op_q;
	mem_op_t    mem_op_q;
	logic       wreg_q;
	reg_addr_t  wd_q;
	reg_addr_t  rs_q;
	reg_addr_t  rt_q;
	logic       use_imm_q;
	word_t      imm_q;
	word_t      rs_val_q;
	word_t      rt_val_q;

	logic       load_use;
	logic       idex_hold;
	word_t      opa_fwd;
	word_t      opb_fwd;

	assign opcode      = id_inst_i[31:26];
	assign funct       = id_inst_i[5:0];
	assign imm_sext    = {{16{id_inst_i[15]}}, id_inst_i[15:0]};
	assign imm_zext    = {16'h0000, id_inst_i[15:0]};
	assign rf_raddr1_o = id_inst_i[25:21];
	assign rf_raddr2_o = id_inst_i[20:16];

	//////////////////////////////////////////////////
	// instruction decode

	always_comb begin
		dec_alu_op  = ALU_ADD;
		dec_mem_op  = MEM_NONE;
		dec_wreg    = 1'b0;
		dec_wd      = id_inst_i[20:16];
		dec_rs      = '0;
		dec_rt      = '0;
		dec_use_imm = 1'b1;
		dec_imm     = imm_sext;
		if (id_valid_i) begin
			case (opcode)
				`OP_SPECIAL: begin
					dec_use_imm = 1'b0;
					dec_wd      = id_inst_i[15:11];
					dec_wreg    = 1'b1;
					dec_rs      = id_inst_i[25:21];
					dec_rt      = id_inst_i[20:16];
					case (funct)
						`FN_ADDU: dec_alu_op = ALU_ADD;
						`FN_SUBU: dec_alu_op = ALU_SUB;
						`FN_AND:  dec_alu_op = ALU_AND;
						`FN_OR:   dec_alu_op = ALU_OR;
						`FN_XOR:  dec_alu_op = ALU_XOR;
						`FN_SLT:  dec_alu_op = ALU_SLT;
						default: begin
							// unsupported funct runs as a nop
							dec_wreg = 1'b0;
							dec_rs   = '0;
							dec_rt   = '0;
						end
					endcase
				end
				`OP_ADDIU: begin
					dec_wreg = 1'b1;
					dec_rs   = id_inst_i[25:21];
				end
				`OP_ORI: begin
					dec_alu_op = ALU_OR;
					dec_wreg   = 1'b1;
					dec_rs     = id_inst_i[25:21];
					dec_imm    = imm_zext;
				end
				`OP_LUI: begin
					dec_alu_op = ALU_LUI;
					dec_wreg   = 1'b1;
					dec_imm    = imm_zext;
				end
				`OP_LW: begin
					dec_mem_op = MEM_LOAD;
					dec_wreg   = 1'b1;
					dec_rs     = id_inst_i[25:21];
				end
				`OP_SW: begin
					dec_mem_op = MEM_STORE;
					dec_rs     = id_inst_i[25:21];
					dec_rt     = id_inst_i[20:16];
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// load-use hazard and ID/EX register

	// load result is not in EX/MEM yet, wait for it in MEM/WB
	assign load_use = (ex_mem_op_i == MEM_LOAD) && ex_wreg_i && (ex_wd_i != '0) &&
		((ex_wd_i == rs_q) || (ex_wd_i == rt_q));
	assign idex_hold    = mem_busy_i || load_use;
	assign fetch_hold_o = idex_hold;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			mem_op_q <= MEM_NONE;
			wreg_q   <= 1'b0;
			rs_q     <= '0;
			rt_q     <= '0;
		end else if (!idex_hold) begin
			mem_op_q <= dec_mem_op;
			wreg_q   <= dec_wreg;
			rs_q     <= dec_rs;
			rt_q     <= dec_rt;
		end
	end

	always_ff @(posedge clk) begin
		if (!idex_hold) begin
			alu_op_q  <= dec_alu_op;
			wd_q      <= dec_wd;
			use_imm_q <= dec_use_imm;
			imm_q     <= dec_imm;
			rs_val_q  <= rf_rdata1_i;
			rt_val_q  <= rf_rdata2_i;
		end else begin
			// keep held operands current with retiring writes
			if (wb_wreg_i && wb_wd_i == rs_q) rs_val_q <= wb_wdata_i;
			if (wb_wreg_i && wb_wd_i == rt_q) rt_val_q <= wb_wdata_i;
		end
	end

	//////////////////////////////////////////////////
	// operand bypass, newest result first

	function automatic word_t bypass(input reg_addr_t src, input word_t stored);
		if (src == '0) return '0;
		if (ex_wreg_i && ex_wd_i == src) return ex_wdata_i;
		if (wb_wreg_i && wb_wd_i == src) return wb_wdata_i;
		return stored;
	endfunction

	always_comb begin
		opa_fwd = bypass(rs_q, rs_val_q);
		opb_fwd = bypass(rt_q, rt_val_q);
	end

	assign ex_alu_op_o     = alu_op_q;
	assign ex_opa_o        = opa_fwd;
	assign ex_opb_o        = use_imm_q ? imm_q : opb_fwd;
	assign ex_store_data_o = opb_fwd;
	assign ex_wd_o         = wd_q;
	// bubble toward EX while the load-use wait lasts
	assign ex_wreg_o       = wreg_q && !load_use;
	assign ex_mem_op_o     = load_use ? MEM_NONE : mem_op_q;

endmodule

//--- fetch_stage.sv
`include "cpu_macros.svh"

module fetch_stage import cpu_pkg::*; (
	input  logic  clk,
	input  logic  reset_i,
	input  logic  hold_i,
	input  word_t imem_data_i,
	output word_t imem_addr_o,
	output word_t id_inst_o,
	output logic  id_valid_o
);

	word_t pc_q;
	word_t inst_q;
	logic  valid_q;

	//////////////////////////////////////////////////
	// program counter, straight-line only

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= `RESET_PC;
		end else if (!hold_i) begin
			pc_q <= pc_q + 32'd4;
		end
	end

	assign imem_addr_o = pc_q;

	//////////////////////////////////////////////////
	// IF/ID register

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= 1'b0;
		end else if (!hold_i) begin
			valid_q <= 1'b1;
		end
	end

	// instruction word itself needs no reset
	always_ff @(posedge clk) begin
		if (!hold_i) begin
			inst_q <= imem_data_i;
		end
	end

	assign id_inst_o  = inst_q;
	assign id_valid_o = valid_q;

	// a stalled fetch must not skip an instruction
	a_pc_hold: assert property (@(posedge clk) disable iff (reset_i)
		hold_i |=> $stable(pc_q))
		else $error("pc moved during fetch hold");

endmodule

//--- regfile.sv
module regfile import cpu_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// $0 reads zero, a write in flight is passed straight through
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0) return '0;
		if (we_i && waddr_i == addr) return wdata_i;
		return regs[addr];
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

//--- cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

	// data word, byte address or instruction
	typedef logic [`DATA_W-1:0] word_t;

	// register file index
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// operation selected for the execute stage
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// data port access kind, whole words only
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_t;

	// four-phase req/ack sequencer in the memory stage
	typedef enum logic [1:0] {
		MS_IDLE,
		MS_REQ,
		MS_RELEASE
	} mem_state_t;

endpackage

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define DATA_W      32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// primary opcodes, inst[31:26]
`define OP_SPECIAL  6'b000000
`define OP_ADDIU    6'b001001
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// funct codes of SPECIAL, inst[5:0]
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_SLT      6'b101010

`endif
